//--- rtl/xc_consts.svh
/*
 * Correlator constants
 * Line count, lag depth, counter width and the layout of the
 * dump frame, shared by the package and the RTL blocks
 */
`ifndef XC_CONSTS_SVH
`define XC_CONSTS_SVH

`define XC_NUM_LINES 4          // Input lines sampled together
`define XC_NUM_LAGS 4           // Auto lags 0..3, cross lags -3..+3
`define XC_RESOLUTION 16        // Counter and frame word width
`define XC_NUM_PAIRS 6          // Line pairs with a < b

// Bank order is totals, then autos, then crosses
`define XC_NUM_COUNTERS 62

`define XC_FRAME_HDR_WORDS 2    // Header word and sample count
`define XC_FRAME_WORDS 64       // Header words plus the whole bank
`define XC_FRAME_MAGIC 8'hA5    // Marker in the top byte of word 0

`endif

//--- rtl/xc_pkg.sv
/*
 * Correlator types
 * Sample word, command byte, counter bank and the frame words
 * that leave the serializer
 */
`include "xc_consts.svh"

package xc_pkg;

	typedef struct packed {
		logic [`XC_NUM_LINES-1:0] lines;    // One bit per input line
	} sample_t;

	typedef enum logic [1:0] {
		CMD_NOP   = 2'd0,
		CMD_START = 2'd1,    // Clear counters and integrate
		CMD_STOP  = 2'd2,
		CMD_DUMP  = 2'd3     // Snapshot and send a frame
	} cmd_op_t;

	typedef struct packed {
		cmd_op_t op;
		logic [5:0] reserved;
	} cmd_t;

	typedef logic [`XC_RESOLUTION-1:0] count_t;

	typedef count_t [`XC_NUM_COUNTERS-1:0] count_bank_t;

	typedef struct packed {
		logic [7:0] magic;
		logic overflow;       // Any counter or the sample count saturated
		logic integrating;
		logic [5:0] reserved;
	} frame_header_t;

	typedef logic [`XC_RESOLUTION-1:0] frame_word_t;

endpackage

//--- rtl/sample_delay_line.sv
/*
 * Sample delay line
 * Keeps the last accepted sample words of all lines in one shift
 * chain, advancing on every valid sample
 */
`timescale 1ns/10ps
`include "xc_consts.svh"

module sample_delay_line (
	input logic intclk,
	input logic reset,
	input xc_pkg::sample_t sample,
	input logic sample_valid,
	output xc_pkg::sample_t [`XC_NUM_LAGS-1:1] history
);

	// history[k] is the sample k valid samples back
	always_ff @(posedge intclk) begin
		if (reset) begin
			history <= '0;    // Delays read as zero after reset
		end else if (sample_valid) begin
			history <= {history[`XC_NUM_LAGS-2:1], sample};
		end
	end

endmodule

//--- rtl/pulse_counter.sv
/*
 * Pulse counter
 * Saturating counter for one correlation product. Clear wins over
 * counting, and a sticky flag marks an increment lost at the top
 */
`timescale 1ns/10ps
`include "xc_consts.svh"

module pulse_counter (
	input logic intclk,
	input logic reset,
	input logic clear,
	input logic count_en,
	output xc_pkg::count_t count,
	output logic overflow
);
	import xc_pkg::*;

	localparam count_t COUNT_MAX = '1;

	always_ff @(posedge intclk) begin
		if (reset || clear) begin
			count <= '0;
			overflow <= 1'b0;
		end else if (count_en) begin
			if (count == COUNT_MAX) begin
				overflow <= 1'b1;    // Hold at max
			end else begin
				count <= count + 1'b1;
			end
		end
	end

endmodule

//--- rtl/correlator_array.sv
/*
 * Correlator array
 * Forms the total, auto and cross product terms of the current
 * sample against the delay history and counts each one in its own
 * saturating counter while integrating. A separate counter keeps
 * the number of integrated samples
 */
`timescale 1ns/10ps
`include "xc_consts.svh"

module correlator_array (
	input logic intclk,
	input logic reset,
	input logic clear,
	input logic integrating,
	input xc_pkg::sample_t sample,
	input logic sample_valid,
	input xc_pkg::sample_t [`XC_NUM_LAGS-1:1] history,
	output wire xc_pkg::count_bank_t counts,
	output xc_pkg::count_t sample_count,
	output logic any_overflow
);
	import xc_pkg::*;

	localparam int CROSS_SPAN = 2 * `XC_NUM_LAGS - 1;    // Lags -3..+3
	localparam int NUM_AUTO = `XC_NUM_LINES * `XC_NUM_LAGS;
	localparam int NUM_CROSS = `XC_NUM_PAIRS * CROSS_SPAN;

	sample_t [`XC_NUM_LAGS-1:0] taps;
	logic [`XC_NUM_LINES-1:0] total_terms;
	logic [NUM_AUTO-1:0] auto_terms;
	logic [NUM_CROSS-1:0] cross_terms;
	logic [`XC_NUM_COUNTERS-1:0] terms;
	wire [`XC_NUM_COUNTERS-1:0] bank_overflow;
	logic sample_overflow;
	logic count_gate;

	assign taps = {history, sample};    // taps[0] is the current sample
	assign count_gate = sample_valid & integrating;
	assign total_terms = sample.lines;

	// Auto products, four lags per line
	for (genvar i = 0; i < `XC_NUM_LINES; i++) begin : g_auto_line
		for (genvar k = 0; k < `XC_NUM_LAGS; k++) begin : g_auto_lag
			assign auto_terms[i*`XC_NUM_LAGS+k] = taps[0].lines[i] & taps[k].lines[i];
		end
	end

	// Cross products, pairs in order (0,1),(0,2),(0,3),(1,2),(1,3),(2,3)
	for (genvar a = 0; a < `XC_NUM_LINES; a++) begin : g_cross_a
		for (genvar b = a + 1; b < `XC_NUM_LINES; b++) begin : g_cross_b
			localparam int PAIR = a * (2 * `XC_NUM_LINES - a - 1) / 2 + b - a - 1;

			for (genvar j = 0; j < CROSS_SPAN; j++) begin : g_cross_lag
				localparam int LAG = j - (`XC_NUM_LAGS - 1);

				if (LAG >= 0) begin : g_pos
					// Line b delayed against line a
					assign cross_terms[PAIR*CROSS_SPAN+j] =
						taps[0].lines[a] & taps[LAG].lines[b];
				end else begin : g_neg
					assign cross_terms[PAIR*CROSS_SPAN+j] =
						taps[-LAG].lines[a] & taps[0].lines[b];
				end
			end
		end
	end

	assign terms = {cross_terms, auto_terms, total_terms};    // Bank order

	for (genvar n = 0; n < `XC_NUM_COUNTERS; n++) begin : g_counter
		pulse_counter i_counter (
			.intclk   (intclk),
			.reset    (reset),
			.clear    (clear),
			.count_en (count_gate & terms[n]),
			.count    (counts[n]),
			.overflow (bank_overflow[n])
		);
	end

	pulse_counter i_sample_counter (
		.intclk   (intclk),
		.reset    (reset),
		.clear    (clear),
		.count_en (count_gate),    // Every integrated sample
		.count    (sample_count),
		.overflow (sample_overflow)
	);

	assign any_overflow = (|bank_overflow) | sample_overflow;

endmodule

//--- rtl/cmd_parser.sv
/*
 * Command parser
 * Accepts command bytes, holds the integrating state and issues
 * the counter clear and dump request pulses
 */
`timescale 1ns/10ps
`include "xc_consts.svh"

module cmd_parser (
	input logic intclk,
	input logic reset,
	input xc_pkg::cmd_t cmd,
	input logic cmd_valid,
	input logic frame_busy,
	output logic cmd_ready,
	output logic integrating,
	output logic clear_counters,
	output logic dump_req
);
	import xc_pkg::*;

	logic cmd_accept;

	// Busy rises on the edge that takes the dump, so ready drops
	// right after it and stays low for the whole frame
	assign cmd_ready = ~frame_busy;
	assign cmd_accept = cmd_valid & cmd_ready;

	assign clear_counters = cmd_accept && (cmd.op == CMD_START);
	assign dump_req = cmd_accept && (cmd.op == CMD_DUMP);    // Snapshot on this edge

	always_ff @(posedge intclk) begin
		if (reset) begin
			integrating <= 1'b0;
		end else if (cmd_accept) begin
			case (cmd.op)
				CMD_START: begin
					integrating <= 1'b1;    // Counts from the next sample
				end
				CMD_STOP: begin
					integrating <= 1'b0;
				end
				default: begin
					integrating <= integrating;    // Nop and dump keep state
				end
			endcase
		end
	end

endmodule

//--- rtl/frame_serializer.sv
/*
 * Frame serializer
 * Freezes the header fields, the sample count and the counter bank
 * on a dump request and sends them as 64 words of 16 bits. A word
 * stays on the port until the sink takes it
 */
`timescale 1ns/10ps
`include "xc_consts.svh"

module frame_serializer (
	input logic intclk,
	input logic reset,
	input logic dump_req,
	input logic integrating,
	input logic any_overflow,
	input xc_pkg::count_bank_t counts,
	input xc_pkg::count_t sample_count,
	output logic frame_busy,
	output xc_pkg::frame_word_t frame_word,
	output logic frame_valid,
	input logic frame_ready
);
	import xc_pkg::*;

	localparam int IDX_W = $clog2(`XC_FRAME_WORDS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`XC_FRAME_WORDS - 1);

	frame_word_t [`XC_FRAME_WORDS-1:0] snapshot;
	frame_header_t header;
	logic [IDX_W-1:0] word_idx;
	logic busy;
	logic word_taken;

	always_comb begin
		header = '0;
		header.magic = `XC_FRAME_MAGIC;
		header.overflow = any_overflow;
		header.integrating = integrating;
	end

	assign word_taken = busy & frame_ready;

	// Snapshot of the whole frame
	always_ff @(posedge intclk) begin
		if (dump_req) begin
			snapshot[0] <= frame_word_t'(header);
			snapshot[1] <= sample_count;
			for (int n = 0; n < `XC_NUM_COUNTERS; n++) begin
				snapshot[`XC_FRAME_HDR_WORDS+n] <= counts[n];
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (reset) begin
			busy <= 1'b0;
			word_idx <= '0;
		end else if (dump_req) begin
			busy <= 1'b1;
			word_idx <= '0;
		end else if (word_taken) begin
			if (word_idx == LAST_IDX) begin
				busy <= 1'b0;    // Last word gone
			end
			word_idx <= word_idx + 1'b1;    // Wraps back to the header
		end
	end

	assign frame_busy = busy;
	assign frame_valid = busy;
	assign frame_word = snapshot[word_idx];

endmodule

//--- rtl/xc_top.sv
/*
 * Multiline correlator top
 * Connects the command parser, the sample delay line, the
 * correlator array and the frame serializer
 */
`timescale 1ns/10ps
`include "xc_consts.svh"

module xc_top (
	input logic intclk,
	input logic reset,
	input xc_pkg::sample_t sample,
	input logic sample_valid,
	input xc_pkg::cmd_t cmd,
	input logic cmd_valid,
	output logic cmd_ready,
	output xc_pkg::frame_word_t frame_word,
	output logic frame_valid,
	input logic frame_ready
);
	import xc_pkg::*;

	logic integrating;
	logic clear_counters;
	logic dump_req;
	logic frame_busy;
	logic any_overflow;
	sample_t [`XC_NUM_LAGS-1:1] history;
	count_bank_t counts;
	count_t sample_count;

	cmd_parser i_cmd_parser (
		.intclk         (intclk),
		.reset          (reset),
		.cmd            (cmd),
		.cmd_valid      (cmd_valid),
		.frame_busy     (frame_busy),
		.cmd_ready      (cmd_ready),
		.integrating    (integrating),
		.clear_counters (clear_counters),
		.dump_req       (dump_req)
	);

	sample_delay_line i_delay_line (
		.intclk       (intclk),
		.reset        (reset),
		.sample       (sample),
		.sample_valid (sample_valid),
		.history      (history)
	);

	correlator_array i_correlator (
		.intclk       (intclk),
		.reset        (reset),
		.clear        (clear_counters),
		.integrating  (integrating),
		.sample       (sample),
		.sample_valid (sample_valid),
		.history      (history),
		.counts       (counts),
		.sample_count (sample_count),
		.any_overflow (any_overflow)
	);

	frame_serializer i_serializer (
		.intclk       (intclk),
		.reset        (reset),
		.dump_req     (dump_req),
		.integrating  (integrating),
		.any_overflow (any_overflow),
		.counts       (counts),
		.sample_count (sample_count),
		.frame_busy   (frame_busy),
		.frame_word   (frame_word),
		.frame_valid  (frame_valid),
		.frame_ready  (frame_ready)
	);

endmodule

//--- bench/xc_tb.sv
/*
 * Correlator testbench
 * Replays the records of the test data file against xc_top, keeps a
 * reference model of every correlation counter and checks each frame
 */
`timescale 1ns/10ps
`include "xc_consts.svh"

module xc_tb;
	import xc_pkg::*;

	localparam int LINES = `XC_NUM_LINES;
	localparam int LAGS = `XC_NUM_LAGS;
	localparam int SPAN = 2 * LAGS - 1;
	localparam int CROSS_BASE = LINES + LINES * LAGS;

	logic intclk;
	logic reset;
	sample_t sample;
	logic sample_valid;
	cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	frame_word_t frame_word;
	logic frame_valid;
	logic frame_ready;

	int checks = 0;
	int value_errors = 0;
	int protocol_errors = 0;
	int ready_pct = 100;
	int wd_cycles = 0;
	frame_word_t frame_q[$];
	logic word_held = 1'b0;
	frame_word_t held_word;

	byte rec_kind[$];
	int rec_a[$];
	int rec_b[$];
	int rec_c[$];
	int rec_d[$];

	logic [LAGS-1:1][LINES-1:0] m_hist;    // Model history with delay k at index k
	count_t m_bank [`XC_NUM_COUNTERS];
	bit m_integ;

	xc_top i_dut (
		.intclk       (intclk),
		.reset        (reset),
		.sample       (sample),
		.sample_valid (sample_valid),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.cmd_ready    (cmd_ready),
		.frame_word   (frame_word),
		.frame_valid  (frame_valid),
		.frame_ready  (frame_ready)
	);

	initial begin
		intclk = 1'b0;
		forever #10 intclk = ~intclk;
	end

	// Sink back-pressure
	initial begin
		frame_ready = 1'b1;
		forever begin
			@(posedge intclk);
			#2;
			frame_ready = ($urandom % 100) < ready_pct;
		end
	end

	// Frame monitor sampled mid-cycle where outputs are settled
	always @(negedge intclk) begin
		if (word_held && (!frame_valid || frame_word !== held_word)) begin
			protocol_errors++;
			$display("Frame word changed or dropped before it was taken at %0t", $time);
		end
		if (frame_valid && cmd_ready) begin
			protocol_errors++;
			$display("Command port ready while a frame was being sent at %0t", $time);
		end
		word_held = frame_valid && !frame_ready;
		held_word = frame_word;
		if (frame_valid && frame_ready) begin
			frame_q.push_back(frame_word);
		end
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge intclk);
		$display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
		$display("test failed");
		$finish;
	end

	function automatic void bump(int idx, logic term);
		if (term && m_bank[idx] != {`XC_RESOLUTION{1'b1}}) begin
			m_bank[idx] = m_bank[idx] + 1'b1;    // Saturates like the hardware
		end
	endfunction

	function automatic void model_sample(logic [LINES-1:0] s);
		logic [LAGS-1:0][LINES-1:0] d;
		int pair;
		d = {m_hist, s};
		pair = 0;
		if (m_integ) begin
			for (int i = 0; i < LINES; i++) begin
				bump(i, d[0][i]);
				for (int k = 0; k < LAGS; k++) begin
					bump(LINES + i * LAGS + k, d[0][i] & d[k][i]);
				end
			end
			for (int a = 0; a < LINES; a++) begin
				for (int b = a + 1; b < LINES; b++) begin
					// Zero lag sits in the middle slot of each pair
					for (int m = 0; m < LAGS; m++) begin
						bump(CROSS_BASE + pair * SPAN + LAGS - 1 + m, d[0][a] & d[m][b]);
						if (m > 0) begin
							bump(CROSS_BASE + pair * SPAN + LAGS - 1 - m, d[m][a] & d[0][b]);
						end
					end
					pair++;
				end
			end
		end
		m_hist = {m_hist[LAGS-2:1], s};    // Shifts whether integrating or not
	endfunction

	task automatic check_header(frame_header_t got, frame_header_t exp, string what);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s magic %h ovf %b integ %b, expected %h %b %b",
				$time, what, got.magic, got.overflow, got.integrating,
				exp.magic, exp.overflow, exp.integrating);
		end
	endtask

	task automatic check_count(count_t got, count_t exp, string what);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic step_sample(logic valid, logic [LINES-1:0] value);
		@(posedge intclk);
		#2;
		sample_valid = valid;
		sample.lines = value;
		if (valid) begin
			model_sample(value);    // Taken on the coming edge
		end
	endtask

	task automatic run_burst(int count, logic [LINES-1:0] value, bit rnd, int gap_pct);
		int sent;
		logic [LINES-1:0] bits;
		sent = 0;
		while (sent < count) begin
			if (gap_pct > 0 && ($urandom % 100) < gap_pct) begin
				step_sample(1'b0, '0);
			end else begin
				bits = rnd ? $urandom : value;
				step_sample(1'b1, bits);
				sent++;
			end
		end
		step_sample(1'b0, '0);
	endtask

	task automatic send_cmd(logic [7:0] code);
		bit taken;
		taken = 1'b0;
		@(posedge intclk);
		#2;
		sample_valid = 1'b0;
		cmd = cmd_t'(code);
		cmd_valid = 1'b1;
		while (!taken) begin
			@(negedge intclk);
			taken = cmd_ready;
			@(posedge intclk);
		end
		#2;
		cmd_valid = 1'b0;
		case (cmd.op)
			CMD_START: begin
				m_integ = 1'b1;
				foreach (m_bank[n]) m_bank[n] = '0;
			end
			CMD_STOP: begin
				m_integ = 1'b0;
			end
		endcase
	endtask

	task automatic do_dump(bit ovf, bit integ, int exp_count, int live);
		frame_header_t exp_hdr;
		count_t exp_bank [`XC_NUM_COUNTERS];
		@(negedge intclk);
		if (frame_valid) begin
			protocol_errors++;
			$display("Frame valid high before the dump command at %0t", $time);
		end
		frame_q.delete();
		send_cmd(8'hC0);
		exp_bank = m_bank;    // Counts at the accepting edge
		exp_hdr = '0;
		exp_hdr.magic = `XC_FRAME_MAGIC;
		exp_hdr.overflow = ovf;
		exp_hdr.integrating = integ;
		if (live > 0) begin
			run_burst(live, '0, 1'b1, 0);
		end
		while (frame_q.size() < `XC_FRAME_WORDS) @(posedge intclk);
		@(negedge intclk);
		if (frame_valid || !cmd_ready || frame_q.size() != `XC_FRAME_WORDS) begin
			protocol_errors++;
			$display("Frame did not end cleanly after %0d words at %0t", frame_q.size(), $time);
		end
		check_header(frame_header_t'(frame_q[0]), exp_hdr, "header");
		check_count(frame_q[1], count_t'(exp_count), "sample count");
		for (int n = 0; n < `XC_NUM_COUNTERS; n++) begin
			check_count(frame_q[`XC_FRAME_HDR_WORDS+n], exp_bank[n],
				$sformatf("counter %0d", n));
		end
	endtask

	initial begin
		int fd;
		int code;
		int want;
		int total;
		int seed;
		byte kind;
		int a;
		int b;
		int c;
		int d;
		logic [8*160-1:0] junk;
		reset = 1'b1;
		sample = '0;
		sample_valid = 1'b0;
		cmd = '0;
		cmd_valid = 1'b0;
		m_hist = '0;
		m_integ = 1'b0;
		foreach (m_bank[n]) m_bank[n] = '0;
		seed = $urandom(45205);
		total = 0;
		fd = $fopen("bench/xc_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test data file bench/xc_testdata.txt");
			$display("test failed");
			$finish;
		end
		while ($fscanf(fd, " %c", kind) == 1) begin
			a = 0;
			b = 0;
			c = 0;
			d = 0;
			want = 1;
			case (kind)
				"#": code = ($fgets(junk, fd) > 0);
				"C": code = $fscanf(fd, "%h", a);
				"S": begin
					want = 3;
					code = $fscanf(fd, "%d %h %d", a, b, c);
				end
				"R": begin
					want = 2;
					code = $fscanf(fd, "%d %d", a, c);
				end
				"B": code = $fscanf(fd, "%d", a);
				"D": begin
					want = 4;
					code = $fscanf(fd, "%d %d %d %d", a, b, c, d);
				end
				default: begin
					code = 0;
				end
			endcase
			if (code != want) begin
				protocol_errors++;
				$display("Unknown or incomplete record of kind %c in the test data file", kind);
			end
			if (kind != "#") begin
				rec_kind.push_back(kind);
				rec_a.push_back(a);
				rec_b.push_back(b);
				rec_c.push_back(c);
				rec_d.push_back(d);
				if (kind == "S" || kind == "R") total += a;
				if (kind == "D") total += d + `XC_FRAME_WORDS;
			end
		end
		$fclose(fd);
		wd_cycles = 3 * total;
		repeat (2) @(posedge intclk);
		#2;
		reset = 1'b0;
		foreach (rec_kind[r]) begin
			case (rec_kind[r])
				"C": send_cmd(rec_a[r][7:0]);
				"S": run_burst(rec_a[r], rec_b[r][LINES-1:0], 1'b0, rec_c[r]);
				"R": run_burst(rec_a[r], '0, 1'b1, rec_c[r]);
				"B": ready_pct = rec_a[r];
				"D": do_dump(rec_a[r][0], rec_b[r][0], rec_c[r], rec_d[r]);
			endcase
		end
		repeat (2) @(posedge intclk);
		$display("checks %0d, value errors %0d, protocol errors %0d",
			checks, value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+rtl
rtl/xc_pkg.sv
rtl/sample_delay_line.sv
rtl/pulse_counter.sv
rtl/correlator_array.sv
rtl/cmd_parser.sv
rtl/frame_serializer.sv
rtl/xc_top.sv
bench/xc_tb.sv

//--- bench/xc_testdata.txt
# Kinds: C cmd_byte(hex) | S count value(hex) gap_pct | R count gap_pct | B ready_pct
# D overflow integrating sample_count live_samples, where live samples run during the frame
# Idle dump straight after reset
D 0 0 0 0
# Fixed patterns while integrating
C 40
S 20 f 0
S 16 5 0
S 16 a 0
S 12 3 25
S 9 c 0
D 0 1 73 0
# Random burst with gaps, stop, then samples that only shift the history
C 40
R 150 30
C 80
R 40 20
D 0 0 150 0
# Same frame again under back-pressure
B 40
D 0 0 150 0
B 100
# Samples keep arriving while the frame goes out
C 40
R 100 10
B 60
D 0 1 100 120
B 100
D 0 1 220 0
# Start clears every counter
C 40
D 0 1 0 0
# Saturation of totals, autos and crosses
C 40
S 65600 f 0
D 1 1 65535 0
# Start drops the overflow flag
C 40
S 5 9 0
D 0 1 5 0
# Nop keeps state, stop clears integrating
C 00
C 80
D 0 0 5 0
